// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src/rv_alu.sv
module rv_alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::word_t   result,
    output logic            zero
);

    logic          sub;
    logic          overflow;
    logic          slt;
    rv_pkg::word_t b_eff;
    rv_pkg::word_t sum;

    // SLT reuses the subtract path
    assign sub   = (op == rv_pkg::ALU_SUB) || (op == rv_pkg::ALU_SLT);
    assign b_eff = sub ? ~b : b;
    assign sum   = a + b_eff + rv_pkg::word_t'(sub);

    assign overflow = (a[31] ~^ b_eff[31]) & (a[31] ^ sum[31]);
    assign slt      = sum[31] ^ overflow; // Signed less-than

    always_comb begin
        case (op)
            rv_pkg::ALU_AND: result = a & b;
            rv_pkg::ALU_OR:  result = a | b;
            rv_pkg::ALU_SLT: result = {31'd0, slt};
            default:         result = sum;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: src/rv_control.sv
module rv_control (
    input  rv_pkg::word_t       instr,
    output logic                reg_write,
    output logic                mem_write,
    output logic                branch,
    output logic                jump,
    output logic                alu_src,
    output rv_pkg::result_sel_e result_sel,
    output rv_pkg::imm_sel_e    imm_sel,
    output rv_pkg::alu_op_e     alu_op
);

    logic [1:0] alu_class; // 00 add, 01 sub, 10 by funct3
    logic [1:0] sub_bits;

    always_comb begin
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        alu_src    = 1'b0;
        result_sel = rv_pkg::RES_ALU;
        imm_sel    = rv_pkg::IMM_I;
        alu_class  = 2'b00;
        case (instr[6:0])
            rv_pkg::OP_LOAD: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                result_sel = rv_pkg::RES_MEM;
            end
            rv_pkg::OP_STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_sel   = rv_pkg::IMM_S;
            end
            rv_pkg::OP_BRANCH: begin
                branch    = 1'b1;
                imm_sel   = rv_pkg::IMM_B;
                alu_class = 2'b01; // Compare by subtraction
            end
            rv_pkg::OP_JAL: begin
                reg_write  = 1'b1;
                jump       = 1'b1;
                imm_sel    = rv_pkg::IMM_J;
                result_sel = rv_pkg::RES_PC4;
            end
            rv_pkg::OP_ALU_IMM: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_class = 2'b10;
            end
            rv_pkg::OP_ALU_REG: begin
                reg_write = 1'b1;
                alu_class = 2'b10;
            end
            default: ; // Unknown opcode, no side effects
        endcase
    end

    // SUB needs both an R-type opcode and funct7 bit 5
    assign sub_bits = {instr[5], instr[30]};

    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        if (alu_class == 2'b01) begin
            alu_op = rv_pkg::ALU_SUB;
        end else if (alu_class == 2'b10) begin
            case (instr[14:12])
                3'b000:  alu_op = (sub_bits == 2'b11) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                3'b010:  alu_op = rv_pkg::ALU_SLT;
                3'b110:  alu_op = rv_pkg::ALU_OR;
                3'b111:  alu_op = rv_pkg::ALU_AND;
                default: alu_op = rv_pkg::ALU_ADD;
            endcase
        end
    end

endmodule

// File: src/rv_core.sv
module rv_core #(
    parameter int DMEM_ADDR_W = 10
) (
    input  logic              clk,
    input  logic              rst,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output logic              wb_en,
    output rv_pkg::reg_addr_t wb_addr,
    output rv_pkg::word_t     wb_data
);

    logic                redirect;
    rv_pkg::word_t       redirect_pc;
    rv_pkg::word_t       if_instr;
    rv_pkg::word_t       if_pc;
    rv_pkg::word_t       if_pc4;

    logic                id_reg_write;
    logic                id_mem_write;
    logic                id_branch;
    logic                id_jump;
    logic                id_alu_src;
    rv_pkg::result_sel_e id_result_sel;
    rv_pkg::alu_op_e     id_alu_op;
    rv_pkg::word_t       id_rd1;
    rv_pkg::word_t       id_rd2;
    rv_pkg::word_t       id_imm;
    rv_pkg::word_t       id_pc;
    rv_pkg::word_t       id_pc4;
    rv_pkg::reg_addr_t   id_rd;

    logic                ex_reg_write;
    logic                ex_mem_write;
    rv_pkg::result_sel_e ex_result_sel;
    rv_pkg::word_t       ex_alu_result;
    rv_pkg::word_t       ex_store_data;
    rv_pkg::word_t       ex_pc4;
    rv_pkg::reg_addr_t   ex_rd;

    rv_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .if_instr    (if_instr),
        .if_pc       (if_pc),
        .if_pc4      (if_pc4)
    );

    // Writeback loops back into the register file here
    rv_decode u_decode (
        .clk           (clk),
        .rst           (rst),
        .if_instr      (if_instr),
        .if_pc         (if_pc),
        .if_pc4        (if_pc4),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .id_reg_write  (id_reg_write),
        .id_mem_write  (id_mem_write),
        .id_branch     (id_branch),
        .id_jump       (id_jump),
        .id_alu_src    (id_alu_src),
        .id_result_sel (id_result_sel),
        .id_alu_op     (id_alu_op),
        .id_rd1        (id_rd1),
        .id_rd2        (id_rd2),
        .id_imm        (id_imm),
        .id_pc         (id_pc),
        .id_pc4        (id_pc4),
        .id_rd         (id_rd)
    );

    rv_execute u_execute (
        .clk           (clk),
        .rst           (rst),
        .id_reg_write  (id_reg_write),
        .id_mem_write  (id_mem_write),
        .id_branch     (id_branch),
        .id_jump       (id_jump),
        .id_alu_src    (id_alu_src),
        .id_result_sel (id_result_sel),
        .id_alu_op     (id_alu_op),
        .id_rd1        (id_rd1),
        .id_rd2        (id_rd2),
        .id_imm        (id_imm),
        .id_pc         (id_pc),
        .id_pc4        (id_pc4),
        .id_rd         (id_rd),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_write  (ex_mem_write),
        .ex_result_sel (ex_result_sel),
        .ex_alu_result (ex_alu_result),
        .ex_store_data (ex_store_data),
        .ex_pc4        (ex_pc4),
        .ex_rd         (ex_rd)
    );

    rv_mem_wb #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) u_mem_wb (
        .clk           (clk),
        .rst           (rst),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_write  (ex_mem_write),
        .ex_result_sel (ex_result_sel),
        .ex_alu_result (ex_alu_result),
        .ex_store_data (ex_store_data),
        .ex_pc4        (ex_pc4),
        .ex_rd         (ex_rd),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data)
    );

endmodule

// File: src/rv_decode.sv
module rv_decode (
    input  logic                clk,
    input  logic                rst,
    input  rv_pkg::word_t       if_instr,
    input  rv_pkg::word_t       if_pc,
    input  rv_pkg::word_t       if_pc4,
    input  logic                wb_en,
    input  rv_pkg::reg_addr_t   wb_addr,
    input  rv_pkg::word_t       wb_data,
    output logic                id_reg_write,
    output logic                id_mem_write,
    output logic                id_branch,
    output logic                id_jump,
    output logic                id_alu_src,
    output rv_pkg::result_sel_e id_result_sel,
    output rv_pkg::alu_op_e     id_alu_op,
    output rv_pkg::word_t       id_rd1,
    output rv_pkg::word_t       id_rd2,
    output rv_pkg::word_t       id_imm,
    output rv_pkg::word_t       id_pc,
    output rv_pkg::word_t       id_pc4,
    output rv_pkg::reg_addr_t   id_rd
);

    logic                reg_write;
    logic                mem_write;
    logic                branch;
    logic                jump;
    logic                alu_src;
    rv_pkg::result_sel_e result_sel;
    rv_pkg::imm_sel_e    imm_sel;
    rv_pkg::alu_op_e     alu_op;
    rv_pkg::word_t       rd1;
    rv_pkg::word_t       rd2;
    rv_pkg::word_t       imm;

    rv_control u_control (
        .instr      (if_instr),
        .reg_write  (reg_write),
        .mem_write  (mem_write),
        .branch     (branch),
        .jump       (jump),
        .alu_src    (alu_src),
        .result_sel (result_sel),
        .imm_sel    (imm_sel),
        .alu_op     (alu_op)
    );

    rv_regfile u_regfile (
        .clk   (clk),
        .rs1   (if_instr[19:15]),
        .rs2   (if_instr[24:20]),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (wb_en),
        .waddr (wb_addr),
        .wdata (wb_data)
    );

    always_comb begin
        case (imm_sel)
            rv_pkg::IMM_S: imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            rv_pkg::IMM_B: imm = {{20{if_instr[31]}}, if_instr[7], if_instr[30:25],
                                  if_instr[11:8], 1'b0};
            rv_pkg::IMM_J: imm = {{12{if_instr[31]}}, if_instr[19:12], if_instr[20],
                                  if_instr[30:21], 1'b0};
            default:       imm = {{20{if_instr[31]}}, if_instr[31:20]};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_reg_write  <= 1'b0;
            id_mem_write  <= 1'b0;
            id_branch     <= 1'b0;
            id_jump       <= 1'b0;
            id_alu_src    <= 1'b0;
            id_result_sel <= rv_pkg::RES_ALU;
            id_alu_op     <= rv_pkg::ALU_ADD;
            id_rd1        <= '0;
            id_rd2        <= '0;
            id_imm        <= '0;
            id_pc         <= '0;
            id_pc4        <= '0;
            id_rd         <= '0;
        end else begin
            id_reg_write  <= reg_write;
            id_mem_write  <= mem_write;
            id_branch     <= branch;
            id_jump       <= jump;
            id_alu_src    <= alu_src;
            id_result_sel <= result_sel;
            id_alu_op     <= alu_op;
            id_rd1        <= rd1;
            id_rd2        <= rd2;
            id_imm        <= imm;
            id_pc         <= if_pc;
            id_pc4        <= if_pc4;
            id_rd         <= if_instr[11:7];
        end
    end

endmodule

// File: src/rv_execute.sv
module rv_execute (
    input  logic                clk,
    input  logic                rst,
    input  logic                id_reg_write,
    input  logic                id_mem_write,
    input  logic                id_branch,
    input  logic                id_jump,
    input  logic                id_alu_src,
    input  rv_pkg::result_sel_e id_result_sel,
    input  rv_pkg::alu_op_e     id_alu_op,
    input  rv_pkg::word_t       id_rd1,
    input  rv_pkg::word_t       id_rd2,
    input  rv_pkg::word_t       id_imm,
    input  rv_pkg::word_t       id_pc,
    input  rv_pkg::word_t       id_pc4,
    input  rv_pkg::reg_addr_t   id_rd,
    output logic                redirect,
    output rv_pkg::word_t       redirect_pc,
    output logic                ex_reg_write,
    output logic                ex_mem_write,
    output rv_pkg::result_sel_e ex_result_sel,
    output rv_pkg::word_t       ex_alu_result,
    output rv_pkg::word_t       ex_store_data,
    output rv_pkg::word_t       ex_pc4,
    output rv_pkg::reg_addr_t   ex_rd
);

    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    logic          alu_zero;

    assign alu_b = id_alu_src ? id_imm : id_rd2;

    rv_alu u_alu (
        .a      (id_rd1),
        .b      (alu_b),
        .op     (id_alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // No flush, the two younger instructions keep going
    assign redirect    = id_jump | (id_branch & alu_zero);
    assign redirect_pc = id_pc + id_imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_reg_write  <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_result_sel <= rv_pkg::RES_ALU;
            ex_alu_result <= '0;
            ex_store_data <= '0;
            ex_pc4        <= '0;
            ex_rd         <= '0;
        end else begin
            ex_reg_write  <= id_reg_write;
            ex_mem_write  <= id_mem_write;
            ex_result_sel <= id_result_sel;
            ex_alu_result <= alu_result;
            ex_store_data <= id_rd2;
            ex_pc4        <= id_pc4;
            ex_rd         <= id_rd;
        end
    end

endmodule

// File: src/rv_fetch.sv
module rv_fetch (
    input  logic          clk,
    input  logic          rst,
    input  logic          redirect,
    input  rv_pkg::word_t redirect_pc,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t if_instr,
    output rv_pkg::word_t if_pc,
    output rv_pkg::word_t if_pc4
);

    rv_pkg::word_t pc;
    rv_pkg::word_t pc4;

    assign pc4       = pc + 32'd4;
    assign imem_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= '0;
            if_instr <= '0;
            if_pc    <= '0;
            if_pc4   <= '0;
        end else begin
            pc       <= redirect ? redirect_pc : pc4; // Taken branch or JAL from execute
            if_instr <= imem_data;
            if_pc    <= pc;
            if_pc4   <= pc4;
        end
    end

endmodule

// File: src/rv_mem_wb.sv
module rv_mem_wb #(
    parameter int DMEM_ADDR_W = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ex_reg_write,
    input  logic                ex_mem_write,
    input  rv_pkg::result_sel_e ex_result_sel,
    input  rv_pkg::word_t       ex_alu_result,
    input  rv_pkg::word_t       ex_store_data,
    input  rv_pkg::word_t       ex_pc4,
    input  rv_pkg::reg_addr_t   ex_rd,
    output logic                wb_en,
    output rv_pkg::reg_addr_t   wb_addr,
    output rv_pkg::word_t       wb_data
);

    rv_pkg::word_t          dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] dmem_idx;

    rv_pkg::result_sel_e mw_result_sel;
    rv_pkg::word_t       mw_load_data;
    rv_pkg::word_t       mw_alu_result;
    rv_pkg::word_t       mw_pc4;

    assign dmem_idx = ex_alu_result[DMEM_ADDR_W+1:2]; // Word index, byte offset dropped

    always_ff @(posedge clk) begin
        if (ex_mem_write) begin
            dmem[dmem_idx] <= ex_store_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en         <= 1'b0;
            wb_addr       <= '0;
            mw_result_sel <= rv_pkg::RES_ALU;
            mw_load_data  <= '0;
            mw_alu_result <= '0;
            mw_pc4        <= '0;
        end else begin
            wb_en         <= ex_reg_write;
            wb_addr       <= ex_rd;
            mw_result_sel <= ex_result_sel;
            mw_load_data  <= dmem[dmem_idx];
            mw_alu_result <= ex_alu_result;
            mw_pc4        <= ex_pc4;
        end
    end

    always_comb begin
        case (mw_result_sel)
            rv_pkg::RES_MEM: wb_data = mw_load_data;
            rv_pkg::RES_PC4: wb_data = mw_pc4; // JAL link value
            default:         wb_data = mw_alu_result;
        endcase
    end

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_BRANCH  = 7'b1100011,
        OP_JAL     = 7'b1101111,
        OP_ALU_IMM = 7'b0010011,
        OP_ALU_REG = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } imm_sel_e;

    // Zero encodes ALU so a cleared pipeline register is harmless
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } result_sel_e;

    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

endpackage

// File: src/rv_regfile.sv
module rv_regfile (
    input  logic              clk,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata
);

    rv_pkg::word_t regs [32];

    // x0 is never stored, reads are forced to zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    // Falling edge so decode sees the value in the same cycle
    always_ff @(negedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// File: verif/rv_core_properties.sv
module rv_core_properties (
    input logic          clk,
    input logic          rst,
    input rv_pkg::word_t imem_addr,
    input logic          wb_en
);

    a_fetch_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
        else $error("imem_addr %h is not word aligned", imem_addr);

    a_no_wb_in_reset: assert property (@(posedge clk) rst |-> !wb_en)
        else $error("wb_en high while rst is asserted");

    // Fetch restarts at the reset vector
    a_reset_vector: assert property (@(posedge clk) $fell(rst) |-> imem_addr == 32'd0)
        else $error("imem_addr is %h in the first cycle after reset", imem_addr);

endmodule

bind rv_core rv_core_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .wb_en     (wb_en)
);

// File: verif/rv_core_tb.sv
module rv_core_tb;

    logic              clk = 1'b0;
    logic              rst;
    rv_pkg::word_t     imem_addr;
    rv_pkg::word_t     imem_data;
    logic              wb_en;
    rv_pkg::reg_addr_t wb_addr;
    rv_pkg::word_t     wb_data;

    rv_pkg::word_t     prog [256];
    logic [7:0]        ptr;
    rv_pkg::reg_addr_t exp_addr [$];
    rv_pkg::word_t     exp_data [$];
    int                checks;
    int                errors;
    string             test_name;

    rv_core #(
        .DMEM_ADDR_W (10)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    always #5 clk = ~clk;

    // Past the program image the core only sees NOPs
    assign imem_data = (imem_addr[31:10] == 22'd0) ? prog[imem_addr[9:2]] : rv_pkg::NOP_INSTR;

    function automatic rv_pkg::word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::OP_ALU_REG};
    endfunction

    function automatic rv_pkg::word_t enc_i(int imm, int rs1, int f3, int rd,
                                            rv_pkg::opcode_e op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic rv_pkg::word_t enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic rv_pkg::word_t enc_b(int off, int rs1, int rs2);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
                rv_pkg::OP_BRANCH};
    endfunction

    function automatic rv_pkg::word_t enc_j(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_pkg::OP_JAL};
    endfunction

    function automatic rv_pkg::word_t sext12(int v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    function automatic rv_pkg::word_t slt_value(rv_pkg::word_t x, rv_pkg::word_t y);
        return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    endfunction

    // NOP padding retires as a zero write to x0
    function automatic logic program_writeback();
        return wb_en && !(wb_addr == 5'd0 && wb_data == 32'd0);
    endfunction

    task automatic put_instr(rv_pkg::word_t instr);
        prog[ptr] = instr;
        ptr = ptr + 8'd1;
    endtask

    task automatic put_spaced(rv_pkg::word_t instr);
        put_instr(instr);
        put_instr(rv_pkg::NOP_INSTR); // Next reader lands three slots later
        put_instr(rv_pkg::NOP_INSTR);
    endtask

    task automatic expect_wb(int rd, rv_pkg::word_t data);
        exp_addr.push_back(rd[4:0]);
        exp_data.push_back(data);
    endtask

    task automatic start_program(string name);
        test_name = name;
        @(posedge clk);
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        foreach (prog[i]) begin
            prog[i] = rv_pkg::NOP_INSTR;
        end
        ptr = 8'd0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic compare_event(int idx);
        checks += 2;
        assert (wb_addr == exp_addr[idx]) else begin
            errors++;
            $display("error at %0t: %s wb_addr expected %0d got %0d", $time, test_name,
                     exp_addr[idx], wb_addr);
        end
        assert (wb_data == exp_data[idx]) else begin
            errors++;
            $display("error at %0t: %s wb_data expected %h got %h", $time, test_name,
                     exp_data[idx], wb_data);
        end
    endtask

    task automatic run_program(int max_cycles);
        int cycles;
        int seen;
        int i;
        cycles = 0;
        seen = 0;
        @(posedge clk);
        rst <= 1'b0;
        while (seen < exp_addr.size() && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
            if (program_writeback()) begin
                compare_event(seen);
                seen++;
            end
        end
        checks++;
        assert (seen == exp_addr.size()) else begin
            errors++;
            $display("%s timed out after %0d cycles with %0d of %0d writebacks seen",
                     test_name, cycles, seen, exp_addr.size());
        end
        for (i = 0; i < 8; i++) begin // Skipped slots must stay silent
            @(negedge clk);
            checks++;
            assert (!program_writeback()) else begin
                errors++;
                $display("%s retired an extra write of %h to x%0d at %0t", test_name,
                         wb_data, wb_addr, $time);
            end
        end
    endtask

    task automatic test_alu();
        int            round;
        int            k;
        int            ia;
        int            ib;
        int            ic;
        int            id;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t c;
        rv_pkg::word_t d;
        rv_pkg::word_t big;
        for (round = 0; round < 4; round++) begin
            start_program("alu");
            ia = $urandom() % 4096;
            ib = $urandom() % 4096;
            ic = $urandom() % 4096;
            id = 1 + $urandom() % 2047;
            a = sext12(ia);
            b = sext12(ib);
            c = sext12(ic);
            d = sext12(id);
            big = sext12(2048) << 20;
            put_spaced(enc_i(ia, 0, 0, 1, rv_pkg::OP_ALU_IMM));
            expect_wb(1, a);
            put_spaced(enc_i(ib, 0, 0, 2, rv_pkg::OP_ALU_IMM));
            expect_wb(2, b);
            put_spaced(enc_r(0, 2, 1, 0, 3));
            expect_wb(3, a + b);
            put_spaced(enc_r(32, 2, 1, 0, 4)); // sub
            expect_wb(4, a - b);
            put_spaced(enc_r(0, 2, 1, 7, 5));
            expect_wb(5, a & b);
            put_spaced(enc_r(0, 2, 1, 6, 6));
            expect_wb(6, a | b);
            put_spaced(enc_r(0, 2, 1, 2, 7));
            expect_wb(7, slt_value(a, b));
            put_spaced(enc_r(0, 1, 2, 2, 11));
            expect_wb(11, slt_value(b, a));
            put_spaced(enc_i(ic, 1, 2, 8, rv_pkg::OP_ALU_IMM)); // slti
            expect_wb(8, slt_value(a, c));
            put_spaced(enc_i(ic, 1, 6, 9, rv_pkg::OP_ALU_IMM));
            expect_wb(9, a | c);
            put_spaced(enc_i(ic, 1, 7, 10, rv_pkg::OP_ALU_IMM));
            expect_wb(10, a & c);
            // Doubling -2048 twenty times reaches the most negative word
            put_spaced(enc_i(2048, 0, 0, 12, rv_pkg::OP_ALU_IMM));
            expect_wb(12, sext12(2048));
            for (k = 1; k <= 20; k++) begin
                put_spaced(enc_r(0, 12, 12, 0, 12));
                expect_wb(12, sext12(2048) << k);
            end
            put_spaced(enc_i(id, 0, 0, 13, rv_pkg::OP_ALU_IMM));
            expect_wb(13, d);
            put_spaced(enc_r(0, 13, 12, 2, 14)); // Subtraction overflows here
            expect_wb(14, slt_value(big, d));
            put_spaced(enc_r(0, 12, 13, 2, 15));
            expect_wb(15, slt_value(d, big));
            run_program(300);
        end
    endtask

    task automatic test_store_load();
        int val [4];
        int k;
        start_program("store_load");
        for (k = 0; k < 4; k++) begin
            val[k] = $urandom() % 4096;
            put_spaced(enc_i(val[k], 0, 0, k + 1, rv_pkg::OP_ALU_IMM));
            expect_wb(k + 1, sext12(val[k]));
        end
        for (k = 0; k < 4; k++) begin
            put_spaced(enc_s(256 + 8 * k, k + 1, 0));
        end
        for (k = 3; k >= 0; k--) begin // Read back in reverse
            put_spaced(enc_i(256 + 8 * k, 0, 2, k + 10, rv_pkg::OP_LOAD));
            expect_wb(k + 10, sext12(val[k]));
        end
        run_program(300);
    endtask

    task automatic test_beq();
        start_program("beq");
        put_spaced(enc_i(7, 0, 0, 1, rv_pkg::OP_ALU_IMM));
        expect_wb(1, 32'd7);
        put_spaced(enc_i(7, 0, 0, 2, rv_pkg::OP_ALU_IMM));
        expect_wb(2, 32'd7);
        put_spaced(enc_i(9, 0, 0, 3, rv_pkg::OP_ALU_IMM));
        expect_wb(3, 32'd9);
        put_instr(enc_b(20, 1, 2)); // Taken but the next two slots still run
        put_instr(enc_i(1, 0, 0, 4, rv_pkg::OP_ALU_IMM));
        expect_wb(4, 32'd1);
        put_instr(enc_i(2, 0, 0, 5, rv_pkg::OP_ALU_IMM));
        expect_wb(5, 32'd2);
        put_instr(enc_i(3, 0, 0, 6, rv_pkg::OP_ALU_IMM));
        put_instr(enc_i(4, 0, 0, 7, rv_pkg::OP_ALU_IMM));
        put_spaced(enc_i(5, 0, 0, 8, rv_pkg::OP_ALU_IMM));
        expect_wb(8, 32'd5);
        // Not taken; a wrong redirect would drop x11
        put_instr(enc_b(16, 1, 3));
        put_instr(enc_i(6, 0, 0, 9, rv_pkg::OP_ALU_IMM));
        expect_wb(9, 32'd6);
        put_instr(enc_i(7, 0, 0, 10, rv_pkg::OP_ALU_IMM));
        expect_wb(10, 32'd7);
        put_instr(enc_i(8, 0, 0, 11, rv_pkg::OP_ALU_IMM));
        expect_wb(11, 32'd8);
        put_instr(enc_i(9, 0, 0, 12, rv_pkg::OP_ALU_IMM));
        expect_wb(12, 32'd9);
        run_program(300);
    endtask

    task automatic test_jal();
        rv_pkg::word_t link;
        start_program("jal");
        put_instr(rv_pkg::NOP_INSTR);
        put_instr(rv_pkg::NOP_INSTR);
        link = {22'd0, ptr, 2'b00} + 32'd4;
        put_instr(enc_j(20, 1));
        expect_wb(1, link);
        put_instr(enc_i(11, 0, 0, 2, rv_pkg::OP_ALU_IMM));
        expect_wb(2, 32'd11);
        put_instr(enc_i(12, 0, 0, 3, rv_pkg::OP_ALU_IMM));
        expect_wb(3, 32'd12);
        put_instr(enc_i(13, 0, 0, 4, rv_pkg::OP_ALU_IMM));
        put_instr(enc_i(14, 0, 0, 5, rv_pkg::OP_ALU_IMM));
        put_instr(enc_i(15, 0, 0, 6, rv_pkg::OP_ALU_IMM)); // Jump target
        expect_wb(6, 32'd15);
        run_program(300);
    endtask

    task automatic test_x0();
        int val;
        start_program("x0");
        val = 1 + $urandom() % 2047;
        put_spaced(enc_i(val, 0, 0, 0, rv_pkg::OP_ALU_IMM));
        expect_wb(0, sext12(val));
        put_spaced(enc_i(21, 0, 0, 1, rv_pkg::OP_ALU_IMM));
        expect_wb(1, 32'd21);
        put_spaced(enc_r(0, 0, 1, 0, 2));
        expect_wb(2, 32'd21);
        put_spaced(enc_r(0, 1, 0, 0, 3));
        expect_wb(3, 32'd21);
        run_program(300);
    endtask

    initial begin
        rst = 1'b1;
        checks = 0;
        errors = 0;
        ptr = 8'd0;
        foreach (prog[i]) begin
            prog[i] = rv_pkg::NOP_INSTR;
        end
        void'($urandom(32'hdf05ec14));
        test_alu();
        test_store_load();
        test_beq();
        test_jal();
        test_x0();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_control.sv
src/rv_alu.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_mem_wb.sv
src/rv_core.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv
